// ==== hw/riscv_isa_pkg.sv ====
/*
    RV32I instruction set definitions
    Major opcodes, the six encoding formats and one word seen through all of them
*/
package riscv_isa_pkg;

    localparam int CPU_INST_BITS = 32;

    //--------------------------------------------------
    // Major opcodes
    //--------------------------------------------------
    // Bits 6:0, low pair is always 11 for 32-bit encodings
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_SYSTEM   = 7'b1110011,
        OPC_MISC_MEM = 7'b0001111
    } opcode_e;

    //--------------------------------------------------
    // Encoding formats, MSB first
    //--------------------------------------------------
    // Register-register
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    // Short immediate, loads and JALR
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    // Stores, immediate split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_type_t;

    // Branches, bit 0 of the offset implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    // LUI and AUIPC
    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    // JAL, scrambled 20-bit offset
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    // Same 32 bits, any format view
    typedef union packed {
        logic [CPU_INST_BITS-1:0] raw;
        r_type_t                  r;
        i_type_t                  i;
        s_type_t                  s;
        b_type_t                  b;
        u_type_t                  u;
        j_type_t                  j;
    } inst_word_u;

endpackage

// ==== hw/uarch_pkg.sv ====
/*
    Front end microarchitecture definitions
    Widths, reset PC, queue sizing and the records passed between stages
*/
package uarch_pkg;

    //--------------------------------------------------
    // Sizing
    //--------------------------------------------------
    localparam int CPU_ADDR_BITS = 32;
    localparam logic [CPU_ADDR_BITS-1:0] RESET_PC = '0;

    // Instruction queue
    localparam int IQ_DEPTH    = 4;
    localparam int IQ_CNT_BITS = 3;
    localparam int IQ_PTR_BITS = $clog2(IQ_DEPTH);

    // Architectural register index
    localparam int ARCH_REG_BITS = 5;

    //--------------------------------------------------
    // Stage records
    //--------------------------------------------------
    // Raw word tagged with its fetch address
    typedef struct packed {
        logic [CPU_ADDR_BITS-1:0]                pc;
        logic [riscv_isa_pkg::CPU_INST_BITS-1:0] inst;
    } fetch_packet_t;

    // Coarse class for the back end
    typedef enum logic [2:0] {
        CLASS_ALU,
        CLASS_ALU_IMM,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_BRANCH,
        CLASS_JUMP,
        CLASS_UPPER,
        CLASS_ILLEGAL
    } inst_class_e;

    // Decoded instruction handed downstream
    typedef struct packed {
        logic [CPU_ADDR_BITS-1:0] pc;
        inst_class_e              inst_class;
        logic [2:0]               funct3;
        logic                     funct7_bit5;
        logic [ARCH_REG_BITS-1:0] rd;
        logic [ARCH_REG_BITS-1:0] rs1;
        logic [ARCH_REG_BITS-1:0] rs2;
        // Sign-extended, zero when the format has none
        logic [CPU_ADDR_BITS-1:0] imm;
        logic                     writes_rd;
    } instruction_t;

endpackage

// ==== hw/fetch.sv ====
/*
    Fetch unit
    Walks the PC, issues one instruction memory request at a time, tags responses
*/
module fetch (
    input  logic                                    clk,
    input  logic                                    arst_n,
    // Redirect from the back end
    input  logic                                    redirect_val,
    input  logic [uarch_pkg::CPU_ADDR_BITS-1:0]     redirect_pc,
    // IMEM request
    input  logic                                    imem_req_rdy,
    output logic                                    imem_req_val,
    output logic [uarch_pkg::CPU_ADDR_BITS-1:0]     imem_req_packet,
    // IMEM receive
    output logic                                    imem_rec_rdy,
    input  logic                                    imem_rec_val,
    input  logic [riscv_isa_pkg::CPU_INST_BITS-1:0] imem_rec_packet,
    // Instruction queue
    input  logic [uarch_pkg::IQ_CNT_BITS-1:0]       iq_free,
    output logic                                    iq_push,
    output uarch_pkg::fetch_packet_t                iq_push_packet
);
    import uarch_pkg::*;

    logic                     fetch_en;
    logic [CPU_ADDR_BITS-1:0] pc;
    logic                     outstanding;
    logic [CPU_ADDR_BITS-1:0] out_pc;
    logic                     stale;
    logic                     req_fire;
    logic                     rec_fire;

    //--------------------------------------------------
    // Request side
    //--------------------------------------------------
    // Nothing in flight and a slot left for the answer
    assign imem_req_val    = fetch_en && !outstanding && (iq_free != '0);
    assign imem_req_packet = pc;
    assign req_fire        = imem_req_val && imem_req_rdy;

    //--------------------------------------------------
    // Receive side
    //--------------------------------------------------
    // Ready exactly while the single request is out
    assign imem_rec_rdy = outstanding;
    assign rec_fire     = imem_rec_val && imem_rec_rdy;

    // Answers to a pre-redirect request are swallowed
    assign iq_push             = rec_fire && !stale && !redirect_val;
    assign iq_push_packet.pc   = out_pc;
    assign iq_push_packet.inst = imem_rec_packet;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fetch_en    <= 1'b0;
            pc          <= RESET_PC;
            outstanding <= 1'b0;
            stale       <= 1'b0;
        end else begin
            // First request goes out once reset has settled
            fetch_en <= 1'b1;
            // Redirect wins over sequential advance
            if (redirect_val) begin
                pc <= redirect_pc;
            end else if (req_fire) begin
                pc <= pc + CPU_ADDR_BITS'(4);
            end
            // Request accepted on a redirect edge is already stale
            if (req_fire) begin
                outstanding <= 1'b1;
                stale       <= redirect_val;
            end else if (rec_fire) begin
                outstanding <= 1'b0;
                stale       <= 1'b0;
            end else if (redirect_val && outstanding) begin
                stale <= 1'b1;
            end
        end
    end

    // Address of the request in flight
    always_ff @(posedge clk) begin
        if (req_fire) begin
            out_pc <= pc;
        end
    end

    // Slot reserved at request time still free when the answer lands
    a_push_room: assert property (@(posedge clk) disable iff (!arst_n)
        iq_push |-> iq_free != '0);

    // Pending request holds its address until taken
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req_val && !imem_req_rdy && !redirect_val
        |=> imem_req_val && $stable(imem_req_packet));

endmodule

// ==== hw/inst_queue.sv ====
/*
    Instruction queue
    Circular buffer of fetch packets between fetch and decode
*/
module inst_queue (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              flush,
    // Write side
    input  logic                              push,
    input  uarch_pkg::fetch_packet_t          push_packet,
    output logic [uarch_pkg::IQ_CNT_BITS-1:0] free,
    // Read side
    input  logic                              pop,
    output logic                              head_val,
    output uarch_pkg::fetch_packet_t          head_packet
);
    import uarch_pkg::*;

    fetch_packet_t          mem [IQ_DEPTH];
    logic [IQ_PTR_BITS-1:0] wr_ptr;
    logic [IQ_PTR_BITS-1:0] rd_ptr;
    logic [IQ_CNT_BITS-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    // Flush beats both push and pop
    assign do_push = push && !flush;
    assign do_pop  = pop && head_val && !flush;

    assign head_val    = (count != '0);
    assign head_packet = mem[rd_ptr];
    assign free        = IQ_CNT_BITS'(IQ_DEPTH) - count;

    //--------------------------------------------------
    // Pointers and occupancy
    //--------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Power-of-two depth, pointers wrap by themselves
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + IQ_CNT_BITS'(do_push) - IQ_CNT_BITS'(do_pop);
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_packet;
        end
    end

    // Decode only takes what is there
    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> head_val);

    // Fetch never overfills
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        push |-> count < IQ_DEPTH);

endmodule

// ==== hw/decode.sv ====
/*
    Decode unit
    Splits RV32I words into fields, builds the immediate, registers the result
*/
module decode (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    // From the instruction queue
    input  logic                     iq_val,
    input  uarch_pkg::fetch_packet_t iq_packet,
    output logic                     iq_pop,
    // To the next stage
    input  logic                     dec_rdy,
    output logic                     dec_val,
    output uarch_pkg::instruction_t  dec_inst
);
    import riscv_isa_pkg::*;
    import uarch_pkg::*;

    inst_word_u   word;
    instruction_t dec_next;
    logic         load_en;

    assign word = iq_packet.inst;

    //--------------------------------------------------
    // Field extraction
    //--------------------------------------------------
    always_comb begin
        dec_next             = '0;
        dec_next.pc          = iq_packet.pc;
        // Register and function fields sit in fixed spots
        dec_next.funct3      = word.r.funct3;
        dec_next.funct7_bit5 = word.r.funct7[5];
        dec_next.rd          = word.r.rd;
        dec_next.rs1         = word.r.rs1;
        dec_next.rs2         = word.r.rs2;

        case (word.r.opcode)
            OPC_OP: begin
                dec_next.inst_class = CLASS_ALU;
            end
            // Fence and system ops ride the I-type path
            OPC_OP_IMM, OPC_MISC_MEM, OPC_SYSTEM: begin
                dec_next.inst_class = CLASS_ALU_IMM;
                dec_next.imm        = {{20{word.i.imm[11]}}, word.i.imm};
            end
            OPC_LOAD: begin
                dec_next.inst_class = CLASS_LOAD;
                dec_next.imm        = {{20{word.i.imm[11]}}, word.i.imm};
            end
            OPC_STORE: begin
                dec_next.inst_class = CLASS_STORE;
                dec_next.imm        = {{20{word.s.imm_11_5[6]}}, word.s.imm_11_5,
                                       word.s.imm_4_0};
            end
            // Halfword-aligned offset
            OPC_BRANCH: begin
                dec_next.inst_class = CLASS_BRANCH;
                dec_next.imm        = {{19{word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
                                       word.b.imm_10_5, word.b.imm_4_1, 1'b0};
            end
            OPC_JAL: begin
                dec_next.inst_class = CLASS_JUMP;
                dec_next.imm        = {{11{word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
                                       word.j.imm_11, word.j.imm_10_1, 1'b0};
            end
            OPC_JALR: begin
                dec_next.inst_class = CLASS_JUMP;
                dec_next.imm        = {{20{word.i.imm[11]}}, word.i.imm};
            end
            // Upper 20 bits, low 12 zero
            OPC_LUI, OPC_AUIPC: begin
                dec_next.inst_class = CLASS_UPPER;
                dec_next.imm        = {word.u.imm_31_12, 12'b0};
            end
            // Unknown opcodes, also any low pair other than 11
            default: begin
                dec_next.inst_class = CLASS_ILLEGAL;
            end
        endcase

        dec_next.writes_rd = !(dec_next.inst_class inside
                               {CLASS_STORE, CLASS_BRANCH, CLASS_ILLEGAL});
    end

    //--------------------------------------------------
    // Output register
    //--------------------------------------------------
    // Load when empty or being drained this cycle
    assign load_en = !dec_val || dec_rdy;
    assign iq_pop  = iq_val && load_en && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_val <= 1'b0;
        end else if (flush) begin
            dec_val <= 1'b0;
        end else if (load_en) begin
            dec_val <= iq_val;
        end
    end

    always_ff @(posedge clk) begin
        if (iq_pop) begin
            dec_inst <= dec_next;
        end
    end

    // Stalled output neither drops nor changes
    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        dec_val && !dec_rdy && !flush |=> dec_val && $stable(dec_inst));

endmodule

// ==== hw/core.sv ====
/*
    Core front end
    Fetch, instruction queue and decode between IMEM and the decode output
*/
module core (
    input  logic                                    clk,
    input  logic                                    arst_n,
    // IMEM ports
    input  logic                                    imem_req_rdy,
    output logic                                    imem_req_val,
    output logic [uarch_pkg::CPU_ADDR_BITS-1:0]     imem_req_packet,
    output logic                                    imem_rec_rdy,
    input  logic                                    imem_rec_val,
    input  logic [riscv_isa_pkg::CPU_INST_BITS-1:0] imem_rec_packet,
    // Redirect, stands in for ROB pc_sel and rob_pc
    input  logic                                    redirect_val,
    input  logic [uarch_pkg::CPU_ADDR_BITS-1:0]     redirect_pc,
    // Decoded output
    input  logic                                    dec_rdy,
    output logic                                    dec_val,
    output uarch_pkg::instruction_t                 dec_inst
);
    import uarch_pkg::*;

    //--------------------------------------------------
    // Fetch
    //--------------------------------------------------
    logic                   iq_push;
    fetch_packet_t          iq_push_packet;
    logic [IQ_CNT_BITS-1:0] iq_free;

    fetch fetch_stage (
        .clk(clk),
        .arst_n(arst_n),
        .redirect_val(redirect_val),
        .redirect_pc(redirect_pc),
        .imem_req_rdy(imem_req_rdy),
        .imem_req_val(imem_req_val),
        .imem_req_packet(imem_req_packet),
        .imem_rec_rdy(imem_rec_rdy),
        .imem_rec_val(imem_rec_val),
        .imem_rec_packet(imem_rec_packet),
        .iq_free(iq_free),
        .iq_push(iq_push),
        .iq_push_packet(iq_push_packet)
    );

    //--------------------------------------------------
    // Instruction queue
    //--------------------------------------------------
    logic          iq_val;
    logic          iq_pop;
    fetch_packet_t iq_packet;

    // Redirect empties the queue
    inst_queue fetch_queue (
        .clk(clk),
        .arst_n(arst_n),
        .flush(redirect_val),
        .push(iq_push),
        .push_packet(iq_push_packet),
        .free(iq_free),
        .pop(iq_pop),
        .head_val(iq_val),
        .head_packet(iq_packet)
    );

    //--------------------------------------------------
    // Decode
    //--------------------------------------------------
    decode decode_stage (
        .clk(clk),
        .arst_n(arst_n),
        .flush(redirect_val),
        .iq_val(iq_val),
        .iq_packet(iq_packet),
        .iq_pop(iq_pop),
        .dec_rdy(dec_rdy),
        .dec_val(dec_val),
        .dec_inst(dec_inst)
    );

endmodule

// ==== verif/tb_decode_model.svh ====
/*
    Reference decode model for the front end testbench
    Expected decode record per RV32I encoding rules, plus program-order PC tracking
*/
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Next PC the decode output should carry
logic [31:0] expected_pc;

// Out of reset, program starts at the reset vector
task automatic track_reset();
    expected_pc = RESET_PC;
endtask

// Sequential stream, one word per accepted output
task automatic track_accept();
    expected_pc = expected_pc + 32'd4;
endtask

// Everything older than the redirect is gone
task automatic track_redirect(logic [31:0] new_pc);
    expected_pc = new_pc;
endtask

//--------------------------------------------------
// Expected record for one word
//--------------------------------------------------
function automatic instruction_t model_decode(logic [31:0] pc, logic [31:0] raw);
    inst_word_u   w;
    instruction_t want;
    w.raw            = raw;
    want             = '0;
    want.pc          = pc;
    // Fixed field positions, taken straight from the raw bits
    want.funct3      = raw[14:12];
    want.funct7_bit5 = raw[30];
    want.rd          = raw[11:7];
    want.rs1         = raw[19:15];
    want.rs2         = raw[24:20];
    want.writes_rd   = 1'b1;
    case (w.i.opcode)
        OPC_OP: begin
            want.inst_class = CLASS_ALU;
        end
        // Fence and system share the I-type layout
        OPC_OP_IMM, OPC_MISC_MEM, OPC_SYSTEM: begin
            want.inst_class = CLASS_ALU_IMM;
            want.imm        = {{20{raw[31]}}, raw[31:20]};
        end
        OPC_LOAD: begin
            want.inst_class = CLASS_LOAD;
            want.imm        = {{20{raw[31]}}, raw[31:20]};
        end
        OPC_STORE: begin
            want.inst_class = CLASS_STORE;
            want.imm        = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            want.writes_rd  = 1'b0;
        end
        OPC_BRANCH: begin
            want.inst_class = CLASS_BRANCH;
            want.imm        = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            want.writes_rd  = 1'b0;
        end
        OPC_JAL: begin
            want.inst_class = CLASS_JUMP;
            want.imm        = {{11{raw[31]}}, raw[31], raw[19:12], raw[20], raw[30:21], 1'b0};
        end
        OPC_JALR: begin
            want.inst_class = CLASS_JUMP;
            want.imm        = {{20{raw[31]}}, raw[31:20]};
        end
        OPC_LUI, OPC_AUIPC: begin
            want.inst_class = CLASS_UPPER;
            want.imm        = {raw[31:12], 12'h000};
        end
        // Reserved opcodes and any 16-bit style low pair
        default: begin
            want.inst_class = CLASS_ILLEGAL;
            want.writes_rd  = 1'b0;
        end
    endcase
    return want;
endfunction

`endif

// ==== verif/tb_core.sv ====
/*
    Core front end testbench
    Random IMEM timing, back-pressure and redirects checked against a reference model
*/
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    import riscv_isa_pkg::*;
    import uarch_pkg::*;

    localparam int          NUM_INSTS  = 3000;
    localparam int          CLK_PERIOD = 8;
    localparam int unsigned SEED       = 32'h3cdd7332;

    logic                     clk;
    logic                     arst_n;
    logic                     imem_req_rdy;
    logic                     imem_req_val;
    logic [CPU_ADDR_BITS-1:0] imem_req_packet;
    logic                     imem_rec_rdy;
    logic                     imem_rec_val;
    logic [CPU_INST_BITS-1:0] imem_rec_packet;
    logic                     redirect_val;
    logic [CPU_ADDR_BITS-1:0] redirect_pc;
    logic                     dec_rdy;
    logic                     dec_val;
    instruction_t             dec_inst;

    // Instruction memory indexed by PC bits 9:2
    logic [CPU_INST_BITS-1:0] imem [256];

    // Memory model state
    logic                     resp_pending;
    logic [CPU_ADDR_BITS-1:0] resp_addr;
    int unsigned              resp_delay;

    // Checker state
    int                       accepted;
    logic                     hold_armed;
    instruction_t             held_inst;
    // Address the next IMEM request should carry
    logic [CPU_ADDR_BITS-1:0] fetch_pc;

    `include "tb_decode_model.svh"

    core DUT (
        .clk(clk),
        .arst_n(arst_n),
        .imem_req_rdy(imem_req_rdy),
        .imem_req_val(imem_req_val),
        .imem_req_packet(imem_req_packet),
        .imem_rec_rdy(imem_rec_rdy),
        .imem_rec_val(imem_rec_val),
        .imem_rec_packet(imem_rec_packet),
        .redirect_val(redirect_val),
        .redirect_pc(redirect_pc),
        .dec_rdy(dec_rdy),
        .dec_val(dec_val),
        .dec_inst(dec_inst)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //--------------------------------------------------
    // Reporting
    //--------------------------------------------------
    task automatic fail_run(string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopping on first error");
    endtask

    task automatic check_value(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t: %s got %0h expected %0h",
                               $time, name, actual, expected));
        end
    endtask

    task automatic check_decoded(instruction_t got, instruction_t want);
        check_value("dec_inst.pc", got.pc, want.pc);
        check_value("dec_inst.inst_class", got.inst_class, want.inst_class);
        check_value("dec_inst.funct3", got.funct3, want.funct3);
        check_value("dec_inst.funct7_bit5", got.funct7_bit5, want.funct7_bit5);
        check_value("dec_inst.rd", got.rd, want.rd);
        check_value("dec_inst.rs1", got.rs1, want.rs1);
        check_value("dec_inst.rs2", got.rs2, want.rs2);
        check_value("dec_inst.imm", got.imm, want.imm);
        check_value("dec_inst.writes_rd", got.writes_rd, want.writes_rd);
    endtask

    //--------------------------------------------------
    // Stimulus helpers
    //--------------------------------------------------
    // Mostly valid opcodes with random fields and some illegal words
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom();
        case ($urandom_range(12, 0))
            0:       w[6:0] = OPC_LUI;
            1:       w[6:0] = OPC_AUIPC;
            2:       w[6:0] = OPC_JAL;
            3:       w[6:0] = OPC_JALR;
            4:       w[6:0] = OPC_BRANCH;
            5:       w[6:0] = OPC_LOAD;
            6:       w[6:0] = OPC_STORE;
            7:       w[6:0] = OPC_OP_IMM;
            8:       w[6:0] = OPC_OP;
            9:       w[6:0] = OPC_SYSTEM;
            10:      w[6:0] = OPC_MISC_MEM;
            11:      w[1:0] = 2'b00;
            default: w[6:0] = 7'b1011011;
        endcase
        return w;
    endfunction

    task automatic fill_imem();
        for (int a = 0; a < 256; a++) begin
            imem[a] = random_word();
        end
    endtask

    // One accepted decode output
    task automatic check_output();
        instruction_t want;
        if (accepted == 0) begin
            check_value("dec_inst.pc (first after reset)", dec_inst.pc, RESET_PC);
        end
        want = model_decode(expected_pc, imem[expected_pc[9:2]]);
        check_decoded(dec_inst, want);
        track_accept();
        accepted++;
    endtask

    // Everything that happens at the coming edge as seen mid-cycle
    task automatic sample_cycle();
        logic req_fire;
        req_fire = imem_req_val && imem_req_rdy;
        check_value("imem_rec_rdy", imem_rec_rdy, resp_pending);
        // Stalled output must not move
        if (hold_armed) begin
            check_value("dec_val (stalled)", dec_val, 1'b1);
            check_value("dec_inst (stalled)", dec_inst, held_inst);
        end
        hold_armed = dec_val && !dec_rdy && !redirect_val;
        held_inst  = dec_inst;
        if (dec_val && dec_rdy) begin
            check_output();
        end
        if (redirect_val) begin
            track_redirect(redirect_pc);
        end
        // Memory side handshakes
        if (imem_rec_val && imem_rec_rdy) begin
            resp_pending = 1'b0;
        end
        if (req_fire) begin
            if (resp_pending) begin
                fail_run("IMEM request accepted while another one was still outstanding");
            end else begin
                check_value("imem_req_packet", imem_req_packet, fetch_pc);
                resp_pending = 1'b1;
                resp_addr    = imem_req_packet;
                resp_delay   = $urandom_range(3, 0);
            end
        end
        // Redirect target beats the sequential step
        if (redirect_val) begin
            fetch_pc = redirect_pc;
        end else if (req_fire) begin
            fetch_pc = fetch_pc + 32'd4;
        end
    endtask

    task automatic drive_cycle();
        imem_req_rdy = ($urandom_range(3, 0) != 0);
        dec_rdy      = ($urandom_range(3, 0) != 0);
        redirect_val = 1'b0;
        // Rare redirects once the reset stream has shown up
        if (accepted > 0 && $urandom_range(99, 0) < 2) begin
            redirect_val = 1'b1;
            redirect_pc  = $urandom() & 32'hffff_fffc;
        end
        // Response raised after its delay and held until taken
        if (!resp_pending) begin
            imem_rec_val = 1'b0;
        end else if (!imem_rec_val) begin
            if (resp_delay == 0) begin
                imem_rec_val    = 1'b1;
                imem_rec_packet = imem[resp_addr[9:2]];
            end else begin
                resp_delay--;
            end
        end
    endtask

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------
    initial begin
        int unsigned seed_draw;
        seed_draw       = $urandom(SEED);
        arst_n          = 1'b0;
        imem_req_rdy    = 1'b0;
        imem_rec_val    = 1'b0;
        imem_rec_packet = '0;
        redirect_val    = 1'b0;
        redirect_pc     = '0;
        dec_rdy         = 1'b0;
        resp_pending    = 1'b0;
        resp_addr       = '0;
        resp_delay      = 0;
        accepted        = 0;
        hold_armed      = 1'b0;
        held_inst       = '0;
        fetch_pc        = RESET_PC;
        fill_imem();
        track_reset();
        // Quiet outputs while in reset
        repeat (10) begin
            @(negedge clk);
            check_value("dec_val (in reset)", dec_val, 1'b0);
            check_value("imem_req_val (in reset)", imem_req_val, 1'b0);
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        while (accepted < NUM_INSTS) begin
            @(negedge clk);
            sample_cycle();
            @(posedge clk);
            #1;
            drive_cycle();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    // Run length bound of 40 cycles per instruction
    initial begin
        repeat (NUM_INSTS * 40) @(posedge clk);
        fail_run($sformatf("Timeout: only %0d of %0d instructions accepted after %0d cycles",
                           accepted, NUM_INSTS, NUM_INSTS * 40));
    end

endmodule

// ==== verilog.f ====
hw/riscv_isa_pkg.sv
hw/uarch_pkg.sv
hw/fetch.sv
hw/inst_queue.sv
hw/decode.sv
hw/core.sv
+incdir+verif
verif/tb_core.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the core front end testbench
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
    -f verilog.f -o tb_core_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_core_sim > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || grep -q "SIMULATION PASSED" sim.log
